//--- lc_cfg.svh
`ifndef LC_CFG_SVH
`define LC_CFG_SVH

// Data path and memory geometry
`define WORD_WIDTH 16
`define MEM_DEPTH 256
`define ADDR_WIDTH 8

// Serial line timing, sysclk cycles per UART bit
`define UART_CLKS_PER_BIT 8

// Memory mapped I/O
// Processor stores to this address land in the LED register
`define LED_ADDR 8'hFF

`endif

//--- lc_bus_pkg.sv
`default_nettype none

`include "lc_cfg.svh"

package lc_bus_pkg;

    // Request into the memory map and the word memory
    typedef struct packed {
        logic                   we;
        logic [`ADDR_WIDTH-1:0] addr;
        logic [`WORD_WIDTH-1:0] wdata;
    } mem_req_t;

    // Read data, only produced for reads
    typedef struct packed {
        logic [`WORD_WIDTH-1:0] data;
    } mem_rsp_t;

    // Serial streams
    typedef struct packed {
        logic [7:0] data;
    } byte_beat_t;

    typedef struct packed {
        logic [`WORD_WIDTH-1:0] data;
    } word_beat_t;

endpackage

`default_nettype wire

//--- lc_isa_pkg.sv
`default_nettype none

package lc_isa_pkg;

    // Unlisted codes decode as no-ops
    typedef enum logic [3:0] {
        OP_LDI  = 4'h1,
        OP_ADD  = 4'h2,
        OP_LW   = 4'h3,
        OP_SW   = 4'h4,
        OP_BNZ  = 4'h5,
        OP_HALT = 4'hF
    } opcode_e;

    // Instruction word layout
    // low holds imm8 for LDI, signed offset for BNZ, rt in [7:6] for ADD and SW
    typedef struct packed {
        opcode_e    op;
        logic [1:0] rd;
        logic [1:0] rs;
        logic [7:0] low;
    } instr_t;

    function automatic logic [1:0] instr_rt(input instr_t ins);
        return ins.low[7:6];
    endfunction

endpackage

`default_nettype wire

//--- uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

`include "lc_cfg.svh"

module uart_rx import lc_bus_pkg::*; (
    input  wire        sysclk,
    input  wire        sysrst,
    input  wire        rx,
    output byte_beat_t byte_out,
    output logic       byte_valid,
    input  wire        byte_ready
);
    localparam int CNT_W    = $clog2(`UART_CLKS_PER_BIT);
    localparam int HALF_BIT = `UART_CLKS_PER_BIT / 2;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    rx_state_e        state;
    logic [1:0]       rx_sync;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift;
    logic             bit_end;

    // Last cycle of a full bit period
    assign bit_end = clk_cnt == CNT_W'(`UART_CLKS_PER_BIT - 1);

    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            state      <= RX_IDLE;
            rx_sync    <= 2'b11;
            clk_cnt    <= '0;
            byte_valid <= 1'b0;
        end else begin
            rx_sync <= {rx_sync[0], rx};
            clk_cnt <= clk_cnt + 1'b1;
            if (byte_valid && byte_ready) begin
                byte_valid <= 1'b0;
            end
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (!rx_sync[1]) state <= RX_START;
                end
                // Recheck the line at mid start bit to reject glitches
                RX_START: if (clk_cnt == CNT_W'(HALF_BIT - 1)) begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    state   <= rx_sync[1] ? RX_IDLE : RX_DATA;
                end
                RX_DATA: if (bit_end) begin
                    clk_cnt <= '0;
                    shift   <= {rx_sync[1], shift[7:1]};
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == 3'd7) state <= RX_STOP;
                end
                // An unaccepted byte is simply overwritten here
                RX_STOP: if (bit_end) begin
                    state         <= RX_IDLE;
                    byte_out.data <= shift;
                    byte_valid    <= 1'b1;
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- uart_sr.sv
`timescale 1ns/1ps
`default_nettype none

module uart_sr import lc_bus_pkg::*; (
    input  wire        sysclk,
    input  wire        sysrst,
    input  byte_beat_t byte_in,
    input  wire        byte_valid,
    output logic       byte_ready,
    output word_beat_t word_out,
    output logic       word_valid,
    input  wire        word_ready
);
    logic [7:0] hi_byte;
    // Set once the high byte of a word is held
    logic       phase;

    // No room for a new byte while a finished word waits
    assign byte_ready = !word_valid;

    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            phase      <= 1'b0;
            word_valid <= 1'b0;
        end else begin
            if (word_valid && word_ready) begin
                word_valid <= 1'b0;
            end
            if (byte_valid && byte_ready) begin
                phase <= !phase;
                if (!phase) begin
                    hi_byte <= byte_in.data;
                end else begin
                    word_out.data <= {hi_byte, byte_in.data};
                    word_valid    <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- word_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "lc_cfg.svh"

module word_mem import lc_bus_pkg::*; (
    input  wire      sysclk,
    input  wire      sysrst,
    input  mem_req_t req,
    input  wire      req_valid,
    output logic     req_ready,
    output mem_rsp_t rsp,
    output logic     rsp_valid
);
    logic [`WORD_WIDTH-1:0] mem [`MEM_DEPTH];

    // Single beat per request, never stalls
    assign req_ready = 1'b1;

    always_ff @(posedge sysclk) begin
        if (req_valid && req_ready) begin
            if (req.we) begin
                mem[req.addr] <= req.wdata;
            end else begin
                rsp.data <= mem[req.addr];
            end
        end
    end

    // Read data is valid the cycle after acceptance
    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= req_valid && req_ready && !req.we;
        end
    end

endmodule

`default_nettype wire

//--- mem_map.sv
`timescale 1ns/1ps
`default_nettype none

`include "lc_cfg.svh"

module mem_map import lc_bus_pkg::*; (
    input  wire                     sysclk,
    input  wire                     sysrst,
    input  mem_req_t                ld_req,
    input  wire                     ld_valid,
    output logic                    ld_ready,
    input  mem_req_t                cpu_req,
    input  wire                     cpu_valid,
    output logic                    cpu_ready,
    output mem_rsp_t                cpu_rsp,
    output logic                    cpu_rsp_valid,
    output logic [`WORD_WIDTH-1:0]  led
);
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;
    logic     mem_valid;
    logic     mem_ready;
    logic     mem_rsp_valid;
    logic     cpu_is_led;
    logic     rsp_to_cpu;

    assign cpu_is_led = cpu_req.we && cpu_req.addr == `LED_ADDR;

    // Loader always wins, the processor waits with valid held
    assign ld_ready  = mem_ready;
    assign cpu_ready = !ld_valid && (cpu_is_led || mem_ready);
    assign mem_req   = ld_valid ? ld_req : cpu_req;
    assign mem_valid = ld_valid || (cpu_valid && !cpu_is_led);

    word_mem u_mem (
        .sysclk    (sysclk),
        .sysrst    (sysrst),
        .req       (mem_req),
        .req_valid (mem_valid),
        .req_ready (mem_ready),
        .rsp       (mem_rsp),
        .rsp_valid (mem_rsp_valid)
    );

    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            led        <= '0;
            rsp_to_cpu <= 1'b0;
        end else begin
            // Remember who owns the read in flight
            rsp_to_cpu <= !ld_valid && cpu_valid && !cpu_req.we && mem_ready;
            if (cpu_valid && cpu_ready && cpu_is_led) led <= cpu_req.wdata;
        end
    end

    assign cpu_rsp       = mem_rsp;
    assign cpu_rsp_valid = mem_rsp_valid && rsp_to_cpu;

endmodule

`default_nettype wire

//--- cpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "lc_cfg.svh"

module cpu import lc_bus_pkg::*, lc_isa_pkg::*; (
    input  wire      sysclk,
    input  wire      rst_n,
    output mem_req_t mem_req,
    output logic     mem_valid,
    input  wire      mem_ready,
    input  mem_rsp_t mem_rsp,
    input  wire      mem_rsp_valid,
    output logic     halted
);
    typedef enum logic [2:0] {
        S_IDLE, S_FETCH, S_FWAIT, S_DECODE, S_EXEC, S_MEM, S_WB, S_HALT
    } cpu_state_e;

    cpu_state_e             state;
    instr_t                 ir;
    logic [`ADDR_WIDTH-1:0] pc;
    logic [`WORD_WIDTH-1:0] regs [4];
    logic [`WORD_WIDTH-1:0] op_a;
    logic [`WORD_WIDTH-1:0] op_b;
    logic [`WORD_WIDTH-1:0] result;
    logic                   wb_fire;

    // LW holds writeback until its read data arrives
    assign wb_fire = state == S_WB && (ir.op != OP_LW || mem_rsp_valid);

    assign mem_valid = state == S_FETCH || state == S_MEM;

    always_comb begin
        mem_req = '0;
        if (state == S_MEM) begin
            mem_req.we    = ir.op == OP_SW;
            mem_req.addr  = op_a[`ADDR_WIDTH-1:0];
            mem_req.wdata = op_b;
        end else begin
            mem_req.addr = pc;
        end
    end

    // Control FSM
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            state  <= S_IDLE;
            pc     <= '0;
            halted <= 1'b0;
        end else begin
            case (state)
                S_IDLE:   state <= S_FETCH;
                S_FETCH:  if (mem_ready) state <= S_FWAIT;
                S_FWAIT: if (mem_rsp_valid) begin
                    pc    <= pc + 1'b1;
                    state <= S_DECODE;
                end
                S_DECODE: state <= S_EXEC;
                S_EXEC: begin
                    case (ir.op)
                        OP_LDI, OP_ADD: state <= S_WB;
                        OP_LW, OP_SW:   state <= S_MEM;
                        OP_HALT: begin
                            halted <= 1'b1;
                            state  <= S_HALT;
                        end
                        OP_BNZ: begin
                            // pc already points past the branch
                            if (op_a != '0) pc <= pc + ir.low;
                            state <= S_FETCH;
                        end
                        default: state <= S_FETCH;
                    endcase
                end
                S_MEM:  if (mem_ready) state <= (ir.op == OP_LW) ? S_WB : S_FETCH;
                S_WB:   if (wb_fire) state <= S_FETCH;
                S_HALT: state <= S_HALT;
                default: state <= S_IDLE;
            endcase
        end
    end

    // Datapath registers
    always_ff @(posedge sysclk) begin
        if (state == S_FWAIT && mem_rsp_valid) ir <= instr_t'(mem_rsp.data);
        if (state == S_DECODE) begin
            op_a <= regs[ir.rs];
            op_b <= regs[instr_rt(ir)];
        end
        if (state == S_EXEC) result <= (ir.op == OP_ADD) ? op_a + op_b : {8'h00, ir.low};
        if (wb_fire) regs[ir.rd] <= (ir.op == OP_LW) ? mem_rsp.data : result;
    end

endmodule

`default_nettype wire

//--- little_computer.sv
`timescale 1ns/1ps
`default_nettype none

`include "lc_cfg.svh"

module little_computer import lc_bus_pkg::*; (
    input  wire                    sysclk,
    input  wire                    sysrst,
    input  wire                    rx,
    input  wire                    load_en,
    output logic [`WORD_WIDTH-1:0] led,
    output logic [`ADDR_WIDTH-1:0] load_count,
    output logic                   running,
    output logic                   halted
);
    typedef enum logic {SEQ_HELD, SEQ_RUNNING} seq_state_e;

    seq_state_e seq_state;
    byte_beat_t rx_byte;
    word_beat_t sr_word;
    mem_req_t   ld_req, cpu_req;
    mem_rsp_t   cpu_rsp;
    logic       rx_valid, rx_ready, sr_valid, sr_ready;
    logic       ld_valid, ld_ready, cpu_valid, cpu_ready, cpu_rsp_valid;
    logic       cpu_halted, load_en_q, cpu_rst_n;

    // Words are taken only while loading, one write in flight at a time
    assign sr_ready  = load_en && !ld_valid;
    // load_en stops the processor in the same cycle it is raised
    assign running   = seq_state == SEQ_RUNNING && !load_en;
    assign halted    = cpu_halted && running;
    assign cpu_rst_n = sysrst && running;

    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            load_en_q  <= 1'b0;
            load_count <= '0;
            ld_valid   <= 1'b0;
            seq_state  <= SEQ_HELD;
        end else begin
            load_en_q <= load_en;
            if (sr_valid && sr_ready) begin
                ld_req   <= '{we: 1'b1, addr: load_count, wdata: sr_word.data};
                ld_valid <= 1'b1;
            end else if (ld_valid && ld_ready) begin
                ld_valid <= 1'b0;
            end
            // Rising load_en restarts the load address
            if (load_en && !load_en_q) load_count <= '0;
            else if (ld_valid && ld_ready) load_count <= load_count + 1'b1;
            if (load_en) seq_state <= SEQ_HELD;
            else if (!load_en_q) seq_state <= SEQ_RUNNING;
        end
    end

    uart_rx u_rx (.sysclk(sysclk), .sysrst(sysrst), .rx(rx), .byte_out(rx_byte),
                  .byte_valid(rx_valid), .byte_ready(rx_ready));

    uart_sr u_sr (.sysclk(sysclk), .sysrst(sysrst), .byte_in(rx_byte),
                  .byte_valid(rx_valid), .byte_ready(rx_ready), .word_out(sr_word),
                  .word_valid(sr_valid), .word_ready(sr_ready));

    mem_map u_map (.sysclk(sysclk), .sysrst(sysrst), .ld_req(ld_req), .ld_valid(ld_valid),
                   .ld_ready(ld_ready), .cpu_req(cpu_req), .cpu_valid(cpu_valid),
                   .cpu_ready(cpu_ready), .cpu_rsp(cpu_rsp), .cpu_rsp_valid(cpu_rsp_valid),
                   .led(led));

    cpu u_cpu (.sysclk(sysclk), .rst_n(cpu_rst_n), .mem_req(cpu_req), .mem_valid(cpu_valid),
               .mem_ready(cpu_ready), .mem_rsp(cpu_rsp), .mem_rsp_valid(cpu_rsp_valid),
               .halted(cpu_halted));

endmodule

`default_nettype wire

//--- little_computer_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module little_computer_asserts import lc_bus_pkg::*; (
    input wire        sysclk,
    input wire        sysrst,
    input wire        load_en,
    input wire        running,
    input wire        cpu_halted,
    input byte_beat_t rx_byte,
    input wire        rx_valid,
    input wire        rx_ready,
    input word_beat_t sr_word,
    input wire        sr_valid,
    input wire        sr_ready,
    input mem_req_t   ld_req,
    input wire        ld_valid,
    input wire        ld_ready,
    input mem_req_t   cpu_req,
    input wire        cpu_valid,
    input wire        cpu_ready
);
    // Number of failed assertions so far
    int unsigned fail_count = 0;

    // A stalled beat keeps valid and payload until it transfers
    rx_hold: assert property (@(posedge sysclk) disable iff (!sysrst)
        rx_valid && !rx_ready |=> rx_valid && $stable(rx_byte))
    else begin
        $error("Byte stream dropped or changed a stalled beat");
        fail_count++;
    end

    sr_hold: assert property (@(posedge sysclk) disable iff (!sysrst)
        sr_valid && !sr_ready |=> sr_valid && $stable(sr_word))
    else begin
        $error("Word stream dropped or changed a stalled beat");
        fail_count++;
    end

    ld_hold: assert property (@(posedge sysclk) disable iff (!sysrst)
        ld_valid && !ld_ready |=> ld_valid && $stable(ld_req))
    else begin
        $error("Loader request dropped or changed while stalled");
        fail_count++;
    end

    // Processor requests vanish legally when its reset is applied
    cpu_hold: assert property (@(posedge sysclk) disable iff (!sysrst || !running)
        cpu_valid && !cpu_ready |=> cpu_valid && $stable(cpu_req))
    else begin
        $error("Processor request dropped or changed while stalled");
        fail_count++;
    end

    // The sequencer stays held for a cycle after any load_en
    held_while_loading: assert property (@(posedge sysclk) disable iff (!sysrst)
        load_en |=> !running)
    else begin
        $error("Processor released the cycle after load_en was high");
        fail_count++;
    end

    // Holding the processor clears its halt flag
    halt_needs_run: assert property (@(posedge sysclk) disable iff (!sysrst)
        !running |=> !cpu_halted)
    else begin
        $error("Processor halt flag kept while the processor is held");
        fail_count++;
    end

endmodule

bind little_computer little_computer_asserts u_asserts (.*);

`default_nettype wire

//--- tb_little_computer.sv
`timescale 1ns/1ps
`default_nettype none

`include "lc_cfg.svh"

module tb_little_computer import lc_isa_pkg::*; ();
    // Rx, shift stage and loader add a few cycles after the last stop bit
    localparam int DRAIN_CYCLES = 8;
    localparam int HALT_LIMIT   = 4000;

    logic                   sysclk, sysrst, rx, load_en;
    logic [`WORD_WIDTH-1:0] led;
    logic [`ADDR_WIDTH-1:0] load_count;
    logic                   running, halted;
    logic [15:0]            image[$];

    little_computer UUT (.sysclk(sysclk), .sysrst(sysrst), .rx(rx), .load_en(load_en),
                         .led(led), .load_count(load_count), .running(running),
                         .halted(halted));

    initial begin
        sysclk = 1'b0;
        forever #2 sysclk = ~sysclk;
    end

    // Bound assertions on the DUT end the run at once
    always @(negedge sysclk) begin
        if (UUT.u_asserts.fail_count != 0) begin
            $display("A bound assertion on the DUT failed");
            $display("STATUS: FAIL");
            $fatal(1);
        end
    end

    function automatic logic [15:0] encode_instr(input opcode_e op, input logic [1:0] rd,
                                                 input logic [1:0] rs, input logic [7:0] low);
        return {op, rd, rs, low};
    endfunction

    task automatic next_cycle();
        @(posedge sysclk);
        #1;
    endtask

    task automatic hold_bit(input logic level);
        rx = level;
        repeat (`UART_CLKS_PER_BIT) next_cycle();
    endtask

    // 8N1 frame, LSB first, then a random idle gap
    task automatic send_byte(input logic [7:0] b);
        int gap;
        gap = $urandom % 7;
        hold_bit(1'b0);
        for (int i = 0; i < 8; i++) hold_bit(b[i]);
        hold_bit(1'b1);
        repeat (gap) next_cycle();
    endtask

    task automatic send_word(input logic [15:0] w);
        send_byte(w[15:8]);
        send_byte(w[7:0]);
    endtask

    task automatic send_image();
        foreach (image[i]) send_word(image[i]);
        repeat (DRAIN_CYCLES) next_cycle();
    endtask

    task automatic wait_halted();
        int n;
        n = 0;
        while (!halted && n < HALT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (!halted) begin
            $display("Processor did not halt within %0d cycles", HALT_LIMIT);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_equal(input logic [15:0] actual, input logic [15:0] expected,
                               input string what);
        assert (actual === expected) else begin
            $display("** Error at %0t ns: %s is 16'h%h, expected 16'h%h",
                     $time, what, actual, expected);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    initial begin
        logic [15:0] data [3];
        logic [15:0] sum;
        logic [15:0] pair;
        logic [7:0]  a, b;
        void'($urandom(32'h8922_4544));
        sysrst  = 1'b0;
        rx      = 1'b1;
        load_en = 1'b1;
        repeat (8) @(posedge sysclk);
        #1 sysrst = 1'b1;
        check_equal(16'(running), 16'd0, "running after reset");
        check_equal(16'(halted), 16'd0, "halted after reset");
        check_equal(led, 16'd0, "led after reset");
        check_equal(16'(load_count), 16'd0, "load_count after reset");

        // Sum of 0x40..0x42, r2 counts down with the -1 stored at 0x3F
        image.delete();
        image.push_back(encode_instr(OP_LDI, 2'd0, 2'd0, 8'h00));
        image.push_back(encode_instr(OP_LDI, 2'd1, 2'd0, 8'h40));
        image.push_back(encode_instr(OP_LDI, 2'd2, 2'd0, 8'h03));
        image.push_back(encode_instr(OP_LW, 2'd3, 2'd1, 8'h00));
        image.push_back(encode_instr(OP_ADD, 2'd0, 2'd0, {2'd3, 6'd0}));
        image.push_back(encode_instr(OP_LDI, 2'd3, 2'd0, 8'h01));
        image.push_back(encode_instr(OP_ADD, 2'd1, 2'd1, {2'd3, 6'd0}));
        image.push_back(encode_instr(OP_LDI, 2'd3, 2'd0, 8'h3F));
        image.push_back(encode_instr(OP_LW, 2'd3, 2'd3, 8'h00));
        image.push_back(encode_instr(OP_ADD, 2'd2, 2'd2, {2'd3, 6'd0}));
        // Back to address 3 from the next pc 11
        image.push_back(encode_instr(OP_BNZ, 2'd0, 2'd2, 8'hF8));
        image.push_back(encode_instr(OP_LDI, 2'd1, 2'd0, `LED_ADDR));
        image.push_back(encode_instr(OP_SW, 2'd0, 2'd1, {2'd0, 6'd0}));
        image.push_back(encode_instr(OP_HALT, 2'd0, 2'd0, 8'h00));
        while (image.size() < 'h3F) image.push_back(16'h0000);
        image.push_back(16'hFFFF);
        sum = 16'h0000;
        for (int i = 0; i < 3; i++) begin
            data[i] = 16'($urandom);
            image.push_back(data[i]);
            sum = sum + data[i];
        end
        send_image();
        check_equal(16'(load_count), 16'(image.size() % 256), "load_count after first load");
        load_en = 1'b0;
        wait_halted();
        check_equal(led, sum, "led after first program");

        // Reload while the processor is still running
        check_equal(16'(running), 16'd1, "running before reload");
        load_en = 1'b1;
        next_cycle();
        check_equal(16'(running), 16'd0, "running after load_en rise");
        check_equal(16'(load_count), 16'd0, "load_count after load_en rise");

        // Second program doubles a + b
        a = 8'($urandom);
        b = 8'($urandom);
        pair = {8'h00, a} + {8'h00, b};
        image.delete();
        image.push_back(encode_instr(OP_LDI, 2'd0, 2'd0, a));
        image.push_back(encode_instr(OP_LDI, 2'd1, 2'd0, b));
        image.push_back(encode_instr(OP_ADD, 2'd2, 2'd0, {2'd1, 6'd0}));
        image.push_back(encode_instr(OP_ADD, 2'd2, 2'd2, {2'd2, 6'd0}));
        image.push_back(encode_instr(OP_LDI, 2'd3, 2'd0, `LED_ADDR));
        image.push_back(encode_instr(OP_SW, 2'd0, 2'd3, {2'd2, 6'd0}));
        image.push_back(encode_instr(OP_HALT, 2'd0, 2'd0, 8'h00));
        send_image();
        check_equal(16'(load_count), 16'(image.size() % 256), "load_count after second load");
        load_en = 1'b0;
        wait_halted();
        check_equal(led, pair + pair, "led after second program");

        // Bytes sent outside a load back up in the shift stage and receiver
        send_word(16'($urandom));
        send_byte(8'($urandom));
        repeat (DRAIN_CYCLES) next_cycle();
        check_equal(16'(load_count), 16'(image.size() % 256), "load_count without load_en");

        if (UUT.u_asserts.fail_count == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("STATUS: FAIL");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+.
lc_bus_pkg.sv
lc_isa_pkg.sv
uart_rx.sv
uart_sr.sv
word_mem.sv
mem_map.sv
cpu.sv
little_computer.sv
little_computer_asserts.sv
tb_little_computer.sv

//--- Makefile
SIM := obj_dir/Vtb_little_computer

.PHONY: all run clean

all: run

$(SIM): list.f $(wildcard *.sv *.svh)
	verilator --binary --timing --assert --top-module tb_little_computer -f list.f

run: $(SIM)
	$(SIM) +verilator+error+limit+100 | tee sim.log
	grep -qx "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
